//--- Makefile
TOP = framebuffer_writer_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP) -f build.f

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^TB PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- build.f
hdl/mem_req_pkg.sv
hdl/frame_geom_pkg.sv
hdl/band_router.sv
hdl/write_coalescer.sv
hdl/write_arbiter.sv
hdl/framebuffer_writer.sv
testbench/framebuffer_writer_tb.sv

//--- hdl/band_router.sv
`timescale 1ns/1ps
`default_nettype none

module band_router #(
    parameter int HRES = 320,
    parameter int VRES = 180,
    parameter int NUM_BANDS = 4
) (
    input wire clk_in,
    input wire rst_in,
    input wire pixel_valid,
    input wire [$clog2(HRES)-1:0] hcount,
    input wire [$clog2(VRES)-1:0] vcount,
    input wire [mem_req_pkg::PIXEL_WIDTH-1:0] color,
    input wire mask_zero,
    input wire frame_end,
    input wire [NUM_BANDS-1:0] band_ready,
    output logic pixel_ready,
    output logic [NUM_BANDS-1:0] band_valid,
    output logic [$clog2(HRES*VRES)-1:0] band_pixel_index,
    output logic [mem_req_pkg::PIXEL_WIDTH-1:0] band_color,
    output logic band_mask_zero,
    output logic band_last
);
    localparam int IDX_W = $clog2(HRES*VRES);
    localparam int BAND_W = (NUM_BANDS > 1) ? $clog2(NUM_BANDS) : 1;
    localparam int BAND_LINES = VRES / NUM_BANDS;

    logic occupied;                  // holding register full
    logic [BAND_W-1:0] band_sel;     // band of the held pixel
    logic [BAND_W-1:0] band_next;
    logic [IDX_W-1:0] index_next;

    // last boundary that vcount has passed
    always_comb begin
        band_next = '0;
        for (int k = 1; k < NUM_BANDS; k++) begin
            if (int'(vcount) >= k * BAND_LINES) band_next = BAND_W'(k);
        end
    end

    assign index_next = IDX_W'(hcount) + IDX_W'(vcount) * IDX_W'(HRES);

    assign pixel_ready = !occupied || band_ready[band_sel];

    always_comb begin
        band_valid = '0;
        band_valid[band_sel] = occupied; // only the decoded band sees it
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            occupied <= 1'b0;
        end else if (pixel_ready) begin
            occupied <= pixel_valid;
        end
    end

    always_ff @(posedge clk_in) begin
        if (pixel_valid && pixel_ready) begin
            band_sel <= band_next;
            band_pixel_index <= index_next;
            band_color <= color;
            band_mask_zero <= mask_zero;
            band_last <= frame_end;
        end
    end

endmodule

`default_nettype wire

//--- hdl/frame_geom_pkg.sv
`default_nettype none

// default screen layout, overridden by the top level parameters
package frame_geom_pkg;

    localparam int DEFAULT_HRES = 320;  // pixels per line
    localparam int DEFAULT_VRES = 180;  // lines per frame

    // horizontal bands, each with its own coalescer
    localparam int DEFAULT_NUM_BANDS = 4;

endpackage

`default_nettype wire

//--- hdl/framebuffer_writer.sv
`timescale 1ns/1ps
`default_nettype none

module framebuffer_writer #(
    parameter int HRES = frame_geom_pkg::DEFAULT_HRES,
    parameter int VRES = frame_geom_pkg::DEFAULT_VRES,
    parameter int NUM_BANDS = frame_geom_pkg::DEFAULT_NUM_BANDS
) (
    input wire clk_in,
    input wire rst_in,
    input wire pixel_valid,
    input wire [$clog2(HRES)-1:0] hcount,
    input wire [$clog2(VRES)-1:0] vcount,
    input wire [mem_req_pkg::PIXEL_WIDTH-1:0] color,
    input wire mask_zero,
    input wire frame_end,
    output logic pixel_ready,
    output logic mem_valid,
    output logic [mem_req_pkg::MEM_ADDR_WIDTH-1:0] mem_addr,
    output logic [mem_req_pkg::MEM_DATA_WIDTH-1:0] mem_data,
    output logic [mem_req_pkg::MEM_STROBE_WIDTH-1:0] mem_strobe,
    input wire mem_ready
);
    localparam int IDX_W = $clog2(HRES*VRES);
    localparam int WA_W = IDX_W - mem_req_pkg::LANE_WIDTH;

    // router to coalescers, pixel fields shared by all bands
    wire [NUM_BANDS-1:0] band_valid;
    wire [NUM_BANDS-1:0] band_ready;
    wire [IDX_W-1:0] band_pixel_index;
    wire [mem_req_pkg::PIXEL_WIDTH-1:0] band_color;
    wire band_mask_zero;
    wire band_last;

    // coalescers to arbiter
    wire [NUM_BANDS-1:0] word_valid;
    wire [NUM_BANDS-1:0] word_ready;
    wire [NUM_BANDS-1:0][WA_W-1:0] word_addr;
    wire [NUM_BANDS-1:0][mem_req_pkg::MEM_DATA_WIDTH-1:0] word_data;
    wire [NUM_BANDS-1:0][mem_req_pkg::MEM_STROBE_WIDTH-1:0] word_strobe;

    band_router #(
        .HRES(HRES),
        .VRES(VRES),
        .NUM_BANDS(NUM_BANDS)
    ) band_router_i (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .pixel_valid(pixel_valid),
        .hcount(hcount),
        .vcount(vcount),
        .color(color),
        .mask_zero(mask_zero),
        .frame_end(frame_end),
        .band_ready(band_ready),
        .pixel_ready(pixel_ready),
        .band_valid(band_valid),
        .band_pixel_index(band_pixel_index),
        .band_color(band_color),
        .band_mask_zero(band_mask_zero),
        .band_last(band_last)
    );

    for (genvar k = 0; k < NUM_BANDS; k++) begin : g_band
        write_coalescer #(
            .HRES(HRES),
            .VRES(VRES)
        ) write_coalescer_i (
            .clk_in(clk_in),
            .rst_in(rst_in),
            .pixel_valid(band_valid[k]),
            .pixel_index(band_pixel_index),
            .color(band_color),
            .mask_zero(band_mask_zero),
            .last(band_last),
            .word_ready(word_ready[k]),
            .pixel_ready(band_ready[k]),
            .word_valid(word_valid[k]),
            .word_addr(word_addr[k]),
            .word_data(word_data[k]),
            .word_strobe(word_strobe[k])
        );
    end

    write_arbiter #(
        .HRES(HRES),
        .VRES(VRES),
        .NUM_BANDS(NUM_BANDS)
    ) write_arbiter_i (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .word_valid(word_valid),
        .word_addr(word_addr),
        .word_data(word_data),
        .word_strobe(word_strobe),
        .mem_ready(mem_ready),
        .word_ready(word_ready),
        .mem_valid(mem_valid),
        .mem_addr(mem_addr),
        .mem_data(mem_data),
        .mem_strobe(mem_strobe)
    );

endmodule

`default_nettype wire

//--- hdl/mem_req_pkg.sv
`default_nettype none

// memory write request format shared by the coalescers and the arbiter
package mem_req_pkg;

    localparam int MEM_ADDR_WIDTH = 27;   // word address, 128-bit words
    localparam int MEM_DATA_WIDTH = 128;
    localparam int MEM_STROBE_WIDTH = 16; // one per byte

    // pixel packing
    localparam int PIXEL_WIDTH = 16;
    localparam int PIXELS_PER_WORD = 8;
    localparam int LANE_WIDTH = 3;        // log2 of PIXELS_PER_WORD

endpackage

`default_nettype wire

//--- hdl/write_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module write_arbiter #(
    parameter int HRES = 320,
    parameter int VRES = 180,
    parameter int NUM_BANDS = 4
) (
    input wire clk_in,
    input wire rst_in,
    input wire [NUM_BANDS-1:0] word_valid,
    input wire [NUM_BANDS-1:0][$clog2(HRES*VRES)-mem_req_pkg::LANE_WIDTH-1:0] word_addr,
    input wire [NUM_BANDS-1:0][mem_req_pkg::MEM_DATA_WIDTH-1:0] word_data,
    input wire [NUM_BANDS-1:0][mem_req_pkg::MEM_STROBE_WIDTH-1:0] word_strobe,
    input wire mem_ready,
    output logic [NUM_BANDS-1:0] word_ready,
    output logic mem_valid,
    output logic [mem_req_pkg::MEM_ADDR_WIDTH-1:0] mem_addr,
    output logic [mem_req_pkg::MEM_DATA_WIDTH-1:0] mem_data,
    output logic [mem_req_pkg::MEM_STROBE_WIDTH-1:0] mem_strobe
);
    localparam int BAND_W = (NUM_BANDS > 1) ? $clog2(NUM_BANDS) : 1;

    logic [BAND_W-1:0] last_grant;  // band served most recently
    logic [BAND_W-1:0] grant_idx;
    logic grant_found;
    logic take;

    // first requester after last_grant, wrapping around
    always_comb begin
        int cand;
        grant_found = 1'b0;
        grant_idx = last_grant;
        for (int i = 1; i <= NUM_BANDS; i++) begin
            cand = (int'(last_grant) + i) % NUM_BANDS;
            if (!grant_found && word_valid[cand]) begin
                grant_found = 1'b1;
                grant_idx = BAND_W'(cand);
            end
        end
    end

    assign take = grant_found && (!mem_valid || mem_ready);

    always_comb begin
        word_ready = '0;
        word_ready[grant_idx] = take;
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            mem_valid <= 1'b0;
            last_grant <= BAND_W'(NUM_BANDS - 1); // band 0 goes first
        end else begin
            if (take) begin
                mem_valid <= 1'b1;
                last_grant <= grant_idx;
            end else if (mem_ready) begin
                mem_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (take) begin
            mem_addr <= mem_req_pkg::MEM_ADDR_WIDTH'(word_addr[grant_idx]); // zero extend
            mem_data <= word_data[grant_idx];
            mem_strobe <= word_strobe[grant_idx];
        end
    end

endmodule

`default_nettype wire

//--- hdl/write_coalescer.sv
`timescale 1ns/1ps
`default_nettype none

module write_coalescer #(
    parameter int HRES = 320,
    parameter int VRES = 180
) (
    input wire clk_in,
    input wire rst_in,
    input wire pixel_valid,
    input wire [$clog2(HRES*VRES)-1:0] pixel_index,
    input wire [mem_req_pkg::PIXEL_WIDTH-1:0] color,
    input wire mask_zero,
    input wire last,
    input wire word_ready,
    output logic pixel_ready,
    output logic word_valid,
    output logic [$clog2(HRES*VRES)-mem_req_pkg::LANE_WIDTH-1:0] word_addr,
    output logic [mem_req_pkg::MEM_DATA_WIDTH-1:0] word_data,
    output logic [mem_req_pkg::MEM_STROBE_WIDTH-1:0] word_strobe
);
    localparam int IDX_W = $clog2(HRES*VRES);
    localparam int LANE_W = mem_req_pkg::LANE_WIDTH;
    localparam int WA_W = IDX_W - LANE_W;
    localparam int PIX_W = mem_req_pkg::PIXEL_WIDTH;
    localparam int LANES = mem_req_pkg::PIXELS_PER_WORD;
    localparam int STRB_W = mem_req_pkg::MEM_STROBE_WIDTH;
    localparam int STRB_PER_LANE = STRB_W / LANES;

    // staging word
    logic [LANES-1:0][PIX_W-1:0] stage_data;
    logic [STRB_W-1:0] stage_strobe;
    logic [WA_W-1:0] stage_addr;
    logic [IDX_W-1:0] next_index;    // index that continues the run
    logic open_word;
    logic pending;                   // staged word closed but not yet emitted

    logic [LANE_W-1:0] lane;
    logic [WA_W-1:0] pix_addr;
    logic [LANES-1:0][PIX_W-1:0] merged_data;
    logic [STRB_W-1:0] merged_strobe;
    logic out_free;
    logic accept;
    logic gap;
    logic closes;
    logic emit_pending;
    logic emit_old;
    logic emit_new;
    logic load_out;
    logic load_stage;

    assign lane = pixel_index[LANE_W-1:0];
    assign pix_addr = pixel_index[IDX_W-1:LANE_W];

    assign out_free = !word_valid || word_ready;
    assign pixel_ready = out_free && !pending;
    assign accept = pixel_valid && pixel_ready;

    assign gap = open_word && (pixel_index != next_index);
    assign closes = (lane == {LANE_W{1'b1}}) || last;

    // staged word with the incoming pixel dropped into its lane
    always_comb begin
        merged_data = stage_data;
        merged_strobe = stage_strobe;
        if (gap || !open_word) begin // fresh word starts empty
            merged_data = '0;
            merged_strobe = '0;
        end
        merged_data[lane] = color;
        merged_strobe[lane*STRB_PER_LANE +: STRB_PER_LANE] = {STRB_PER_LANE{!mask_zero}};
    end

    assign emit_pending = pending && out_free;
    assign emit_old = accept && gap;               // old word out, pixel seeds a new one
    assign emit_new = accept && !gap && closes;    // pixel completes the open word
    assign load_out = emit_pending || emit_old || emit_new;
    assign load_stage = accept && (gap || !closes);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            word_valid <= 1'b0;
            open_word <= 1'b0;
            pending <= 1'b0;
        end else begin
            if (load_out) begin
                word_valid <= 1'b1;
            end else if (word_ready) begin
                word_valid <= 1'b0;
            end

            if (emit_pending) begin
                pending <= 1'b0;
            end else if (emit_old) begin
                pending <= closes; // gap pixel that also ends its word
            end

            if (emit_pending || emit_new) begin
                open_word <= 1'b0;
            end else if (load_stage) begin
                open_word <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (emit_pending || emit_old) begin
            word_addr <= stage_addr;
            word_data <= stage_data;
            word_strobe <= stage_strobe;
        end else if (emit_new) begin
            word_addr <= pix_addr;
            word_data <= merged_data;
            word_strobe <= merged_strobe;
        end

        if (load_stage) begin
            stage_data <= merged_data;
            stage_strobe <= merged_strobe;
            stage_addr <= pix_addr;
        end

        if (accept) begin
            next_index <= pixel_index + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- testbench/framebuffer_writer_stim.txt
# P hcount vcount color mask_zero last (hex), pixels in drive order
# W band word_address data strobe (hex), expected words in order within each band
P 00 0 1000 0 0
P 01 0 1001 0 0
P 02 0 1002 0 0
P 03 0 1003 0 0
P 04 0 1004 0 0
P 05 0 1005 0 0
P 06 0 1006 0 0
P 07 0 1007 0 0
W 0 00 10071006100510041003100210011000 ffff
P 00 2 2000 0 0
P 01 2 2001 0 0
P 02 2 2002 0 0
P 0b 2 2103 0 0
P 14 2 2204 0 1
W 1 08 00000000000000000000200220012000 003f
W 1 09 00000000000000002103000000000000 00c0
W 1 0a 00000000000022040000000000000000 0300
P 03 6 4003 0 0
P 04 6 4004 0 1
W 3 18 00000000000040044003000000000000 03c0
P 1f 7 4107 0 1
W 3 1f 41070000000000000000000000000000 c000
P 05 1 5005 0 0
P 05 3 6005 0 0
P 05 5 7005 1 0
P 05 7 8005 0 0
P 06 1 5006 1 0
P 06 3 6006 0 0
P 06 5 7006 0 0
P 06 7 8006 0 0
P 07 1 5007 0 0
P 07 3 6007 0 0
P 07 5 7007 1 0
P 07 7 8007 0 0
W 0 04 50075006500500000000000000000000 cc00
W 1 0c 60076006600500000000000000000000 fc00
W 2 14 70077006700500000000000000000000 3000
W 3 1c 80078006800500000000000000000000 fc00

//--- testbench/framebuffer_writer_tb.sv
`timescale 1ns/1ps
`default_nettype none

module framebuffer_writer_tb;

    localparam int HRES = 32;
    localparam int VRES = 8;
    localparam int NUM_BANDS = 4;
    localparam int H_W = $clog2(HRES);
    localparam int V_W = $clog2(VRES);
    localparam int PIX_W = mem_req_pkg::PIXEL_WIDTH;
    localparam int LANES = mem_req_pkg::PIXELS_PER_WORD;
    localparam int WORDS_PER_BAND = HRES * VRES / NUM_BANDS / LANES;
    localparam int MAX_REC = 64;

    logic clk_in;
    logic rst_in;
    logic pixel_valid;
    logic [H_W-1:0] hcount;
    logic [V_W-1:0] vcount;
    logic [PIX_W-1:0] color;
    logic mask_zero;
    logic frame_end;
    logic pixel_ready;
    logic mem_valid;
    logic [mem_req_pkg::MEM_ADDR_WIDTH-1:0] mem_addr;
    logic [mem_req_pkg::MEM_DATA_WIDTH-1:0] mem_data;
    logic [mem_req_pkg::MEM_STROBE_WIDTH-1:0] mem_strobe;
    logic mem_ready;

    // pixel and word records from the stim file
    int p_h [MAX_REC];
    int p_v [MAX_REC];
    int p_color [MAX_REC];
    int p_mask [MAX_REC];
    int p_last [MAX_REC];
    int w_band [MAX_REC];
    int w_addr [MAX_REC];
    logic [127:0] w_data [MAX_REC];
    int w_strobe [MAX_REC];
    int num_p = 0;
    int num_w = 0;
    int head [NUM_BANDS] = '{default: 0}; // next record to match, per band

    int cycle = 0;
    int limit = 0;
    int close_cycle = -1;   // accept of the first word-closing pixel
    int got_words = 0;
    int value_errors = 0;
    int protocol_errors = 0;
    int stim_errors = 0;
    logic first_seen = 1'b0;
    logic was_reset = 1'b0;
    logic stalled = 1'b0;
    logic [mem_req_pkg::MEM_ADDR_WIDTH-1:0] held_addr;
    logic [mem_req_pkg::MEM_DATA_WIDTH-1:0] held_data;
    logic [mem_req_pkg::MEM_STROBE_WIDTH-1:0] held_strobe;

    framebuffer_writer #(
        .HRES(HRES),
        .VRES(VRES),
        .NUM_BANDS(NUM_BANDS)
    ) framebuffer_writer_i (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .pixel_valid(pixel_valid),
        .hcount(hcount),
        .vcount(vcount),
        .color(color),
        .mask_zero(mask_zero),
        .frame_end(frame_end),
        .pixel_ready(pixel_ready),
        .mem_valid(mem_valid),
        .mem_addr(mem_addr),
        .mem_data(mem_data),
        .mem_strobe(mem_strobe),
        .mem_ready(mem_ready)
    );

    initial begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    // memory side held ready until the first word, random after that
    initial begin
        mem_ready = 1'b1;
        void'($urandom(32'hcb67f32d));
        wait (first_seen);
        forever begin
            @(posedge clk_in);
            #1 mem_ready = ($urandom % 4) != 0;
        end
    end

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        assert (actual == expected) else begin
            value_errors++;
            $display("ERR %s expected %h got %h", name, expected, actual);
        end
    endtask

    // band follows from the address, then compare with that band's next record
    task automatic match_word();
        int band;
        int j;
        band = int'(mem_addr) / WORDS_PER_BAND;
        j = (band < NUM_BANDS) ? head[band] : num_w;
        while (j < num_w && w_band[j] != band) begin
            j++;
        end
        assert (j < num_w) else begin
            protocol_errors++;
            $display("unexpected extra word at address %h (band %0d)", mem_addr, band);
        end
        if (j < num_w) begin
            check_value("mem_addr", 128'(w_addr[j]), 128'(mem_addr));
            check_value("mem_data", w_data[j], mem_data);
            check_value("mem_strobe", 128'(w_strobe[j]), 128'(mem_strobe));
            head[band] = j + 1;
            got_words++;
        end
    endtask

    always @(posedge clk_in) begin
        int idx;
        cycle = cycle + 1;
        if (rst_in) begin
            stalled = 1'b0;
            was_reset = 1'b1;
        end else begin
            if (was_reset) begin
                assert (!mem_valid) else begin
                    protocol_errors++;
                    $display("mem_valid is high right after reset");
                end
                was_reset = 1'b0;
            end
            if (pixel_valid && pixel_ready && close_cycle < 0) begin
                idx = int'(hcount) + HRES * int'(vcount);
                if (idx % LANES == LANES - 1 || frame_end) close_cycle = cycle;
            end
            if (stalled) begin
                assert (mem_valid) else begin
                    protocol_errors++;
                    $display("mem_valid dropped while the word was stalled");
                end
                check_value("mem_addr", 128'(held_addr), 128'(mem_addr));
                check_value("mem_data", held_data, mem_data);
                check_value("mem_strobe", 128'(held_strobe), 128'(mem_strobe));
            end
            if (mem_valid && !first_seen) begin
                first_seen = 1'b1;
                assert (cycle == close_cycle + 3) else begin
                    protocol_errors++;
                    $display("first word came %0d cycles after its pixel instead of 3",
                             cycle - close_cycle);
                end
            end
            if (mem_valid && mem_ready) match_word();
            stalled = mem_valid && !mem_ready;
            held_addr = mem_addr;
            held_data = mem_data;
            held_strobe = mem_strobe;
        end
    end

    initial begin
        @(posedge clk_in);
        wait (cycle >= limit);
        $display("timeout after %0d cycles, %0d of %0d words arrived", cycle, got_words, num_w);
        $display("errors: %0d value, %0d protocol, %0d stim",
                 value_errors, protocol_errors, stim_errors);
        $display("TB FAILED");
        $finish;
    end

    task automatic load_stim();
        int fd;
        int code;
        int a;
        int b;
        int c;
        int d;
        int e;
        logic [127:0] data;
        string line;
        fd = $fopen("testbench/framebuffer_writer_stim.txt", "r");
        assert (fd != 0) else begin
            stim_errors++;
            $display("cannot open the stim file");
        end
        while (fd != 0 && !$feof(fd) && num_p < MAX_REC && num_w < MAX_REC) begin
            code = $fgets(line, fd);
            if (code > 0 && $sscanf(line, "P %h %h %h %h %h", a, b, c, d, e) == 5) begin
                p_h[num_p] = a;
                p_v[num_p] = b;
                p_color[num_p] = c;
                p_mask[num_p] = d;
                p_last[num_p] = e;
                num_p++;
            end else if (code > 0 && $sscanf(line, "W %h %h %h %h", a, b, data, c) == 4) begin
                w_band[num_w] = a;
                w_addr[num_w] = b;
                w_data[num_w] = data;
                w_strobe[num_w] = c;
                num_w++;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        assert (num_p > 0 && num_w > 0) else begin
            stim_errors++;
            $display("stim file holds no usable records");
        end
    endtask

    // called 1 ns after an edge, returns 1 ns after the accepting edge
    task automatic send_pixel(input int i);
        pixel_valid = 1'b1;
        hcount = H_W'(p_h[i]);
        vcount = V_W'(p_v[i]);
        color = PIX_W'(p_color[i]);
        mask_zero = (p_mask[i] != 0);
        frame_end = (p_last[i] != 0);
        @(posedge clk_in);
        while (!pixel_ready) begin
            @(posedge clk_in);
        end
        #1;
    endtask

    initial begin
        rst_in = 1'b1;
        pixel_valid = 1'b0;
        hcount = '0;
        vcount = '0;
        color = '0;
        mask_zero = 1'b0;
        frame_end = 1'b0;
        load_stim();
        limit = 50 * (num_p + num_w);
        repeat (10) @(posedge clk_in);
        #1 rst_in = 1'b0;
        for (int i = 0; i < num_p; i++) begin
            send_pixel(i);
        end
        pixel_valid = 1'b0;
        frame_end = 1'b0;
        wait (got_words == num_w);
        repeat (20) @(posedge clk_in); // room for a stray word
        $display("errors: %0d value, %0d protocol, %0d stim",
                 value_errors, protocol_errors, stim_errors);
        if (value_errors == 0 && protocol_errors == 0 && stim_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
